// File: Bender.yml
package:
  name: id_stage

sources:
  - common/id_pkg.sv
  - decoder/id_decoder.sv
  - verilog/id_operands.sv
  - verilog/id_fsm.sv
  - verilog/id_stage.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_id_stage.sv

// File: common/id_pkg.sv
package id_pkg;

	// widths with a meaning of their own
	typedef logic [31:0] instr_t;
	typedef logic [31:0] data_t;
	typedef logic [4:0] reg_addr_t;

	// major opcodes of the integer subset
	typedef enum logic [6:0] {
		OPCODE_LOAD   = 7'h03,
		OPCODE_OP_IMM = 7'h13,
		OPCODE_AUIPC  = 7'h17,
		OPCODE_STORE  = 7'h23,
		OPCODE_OP     = 7'h33,
		OPCODE_LUI    = 7'h37,
		OPCODE_BRANCH = 7'h63,
		OPCODE_JALR   = 7'h67,
		OPCODE_JAL    = 7'h6f
	} opcode_e;

	typedef enum logic [4:0] {
		ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND,
		ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU,
		// comparisons used by branches
		ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
	} alu_op_e;

	// operand a source, fwd is the last lsu address
	typedef enum logic [1:0] {OP_A_REG_A, OP_A_FWD, OP_A_CURRPC, OP_A_ZERO} op_a_sel_e;

	typedef enum logic {OP_B_REG_B, OP_B_IMM} op_b_sel_e;

	typedef enum logic [2:0] {
		IMM_B_I, IMM_B_S, IMM_B_B, IMM_B_U, IMM_B_J,
		IMM_B_INCR_PC, IMM_B_INCR_ADDR
	} imm_b_sel_e;

	typedef enum logic [1:0] {LSU_TYPE_W = 2'd0, LSU_TYPE_H = 2'd1, LSU_TYPE_B = 2'd2} lsu_type_e;

	typedef enum logic {FIRST_CYCLE, MULTI_CYCLE} id_state_e;

endpackage

// File: decoder/id_decoder.sv
`timescale 1ns/1ps

module id_decoder import id_pkg::*; #(
	parameter bit RV32E = 1'b0
) (
	input  instr_t     instr_i,
	input  logic       instr_first_cycle_i,
	output reg_addr_t  rf_raddr_a_o,
	output reg_addr_t  rf_raddr_b_o,
	output reg_addr_t  rf_waddr_o,
	output logic       rf_we_o,
	output alu_op_e    alu_operator_o,
	output op_a_sel_e  op_a_sel_o,
	output op_b_sel_e  op_b_sel_o,
	output imm_b_sel_e imm_b_sel_o,
	output logic       lsu_req_o,
	output logic       lsu_we_o,
	output lsu_type_e  lsu_type_o,
	output logic       lsu_sign_ext_o,
	output logic       branch_in_dec_o,
	output logic       jump_in_dec_o,
	output logic       illegal_insn_o
);

	opcode_e opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic rs1_used;
	logic rs2_used;
	logic rd_used;

	assign opcode = opcode_e'(instr_i[6:0]);
	assign funct3 = instr_i[14:12];
	assign funct7 = instr_i[31:25];

	assign rf_raddr_a_o = instr_i[19:15];
	assign rf_raddr_b_o = instr_i[24:20];
	assign rf_waddr_o   = instr_i[11:7];

	always_comb begin
		rf_we_o         = 1'b0;
		alu_operator_o  = ALU_ADD;
		op_a_sel_o      = OP_A_REG_A;
		op_b_sel_o      = OP_B_IMM;
		imm_b_sel_o     = IMM_B_I;
		lsu_req_o       = 1'b0;
		lsu_we_o        = 1'b0;
		lsu_type_o      = LSU_TYPE_W;
		lsu_sign_ext_o  = 1'b0;
		branch_in_dec_o = 1'b0;
		jump_in_dec_o   = 1'b0;
		illegal_insn_o  = 1'b0;
		rs1_used        = 1'b1;
		rs2_used        = 1'b0;
		rd_used         = 1'b1;

		case (opcode)
			OPCODE_JAL, OPCODE_JALR: begin
				jump_in_dec_o = 1'b1;
				rs1_used      = (opcode == OPCODE_JALR);
				if (opcode == OPCODE_JALR && funct3 != 3'b000) illegal_insn_o = 1'b1;
				if (instr_first_cycle_i) begin
					// target: pc + j-imm or rs1 + i-imm
					op_a_sel_o  = (opcode == OPCODE_JAL) ? OP_A_CURRPC : OP_A_REG_A;
					imm_b_sel_o = (opcode == OPCODE_JAL) ? IMM_B_J : IMM_B_I;
				end else begin
					// link address in the second cycle
					op_a_sel_o  = OP_A_CURRPC;
					imm_b_sel_o = IMM_B_INCR_PC;
					rf_we_o     = 1'b1;
				end
			end
			OPCODE_BRANCH: begin
				branch_in_dec_o = 1'b1;
				rs2_used        = 1'b1;
				rd_used         = 1'b0;
				if (instr_first_cycle_i) begin
					op_b_sel_o = OP_B_REG_B;
					case (funct3)
						3'b000:  alu_operator_o = ALU_EQ;
						3'b001:  alu_operator_o = ALU_NE;
						3'b100:  alu_operator_o = ALU_LT;
						3'b101:  alu_operator_o = ALU_GE;
						3'b110:  alu_operator_o = ALU_LTU;
						3'b111:  alu_operator_o = ALU_GEU;
						default: illegal_insn_o = 1'b1;
					endcase
				end else begin
					op_a_sel_o  = OP_A_CURRPC;
					imm_b_sel_o = IMM_B_B;
				end
			end
			OPCODE_LOAD: begin
				lsu_req_o      = 1'b1;
				rf_we_o        = 1'b1;
				lsu_sign_ext_o = ~funct3[2];
				case (funct3[1:0])
					2'b00:   lsu_type_o = LSU_TYPE_B;
					2'b01:   lsu_type_o = LSU_TYPE_H;
					2'b10:   lsu_type_o = LSU_TYPE_W;
					default: illegal_insn_o = 1'b1;
				endcase
				// no unsigned word load in rv32
				if (funct3 == 3'b110) illegal_insn_o = 1'b1;
			end
			OPCODE_STORE: begin
				lsu_req_o   = 1'b1;
				lsu_we_o    = 1'b1;
				imm_b_sel_o = IMM_B_S;
				rs2_used    = 1'b1;
				rd_used     = 1'b0;
				case (funct3)
					3'b000:  lsu_type_o = LSU_TYPE_B;
					3'b001:  lsu_type_o = LSU_TYPE_H;
					3'b010:  lsu_type_o = LSU_TYPE_W;
					default: illegal_insn_o = 1'b1;
				endcase
			end
			OPCODE_LUI, OPCODE_AUIPC: begin
				op_a_sel_o  = (opcode == OPCODE_LUI) ? OP_A_ZERO : OP_A_CURRPC;
				imm_b_sel_o = IMM_B_U;
				rf_we_o     = 1'b1;
				rs1_used    = 1'b0;
			end
			OPCODE_OP_IMM: begin
				rf_we_o = 1'b1;
				case (funct3)
					3'b000: alu_operator_o = ALU_ADD;
					3'b010: alu_operator_o = ALU_SLT;
					3'b011: alu_operator_o = ALU_SLTU;
					3'b100: alu_operator_o = ALU_XOR;
					3'b110: alu_operator_o = ALU_OR;
					3'b111: alu_operator_o = ALU_AND;
					3'b001: begin
						alu_operator_o = ALU_SLL;
						if (funct7 != 7'b0000000) illegal_insn_o = 1'b1;
					end
					default: begin
						// srli or srai, shamt in [24:20]
						alu_operator_o = funct7[5] ? ALU_SRA : ALU_SRL;
						if ({funct7[6], funct7[4:0]} != 6'b0) illegal_insn_o = 1'b1;
					end
				endcase
			end
			OPCODE_OP: begin
				rf_we_o    = 1'b1;
				op_b_sel_o = OP_B_REG_B;
				rs2_used   = 1'b1;
				case ({funct7, funct3})
					{7'b0000000, 3'b000}: alu_operator_o = ALU_ADD;
					{7'b0100000, 3'b000}: alu_operator_o = ALU_SUB;
					{7'b0000000, 3'b001}: alu_operator_o = ALU_SLL;
					{7'b0000000, 3'b010}: alu_operator_o = ALU_SLT;
					{7'b0000000, 3'b011}: alu_operator_o = ALU_SLTU;
					{7'b0000000, 3'b100}: alu_operator_o = ALU_XOR;
					{7'b0000000, 3'b101}: alu_operator_o = ALU_SRL;
					{7'b0100000, 3'b101}: alu_operator_o = ALU_SRA;
					{7'b0000000, 3'b110}: alu_operator_o = ALU_OR;
					{7'b0000000, 3'b111}: alu_operator_o = ALU_AND;
					default:              illegal_insn_o = 1'b1;
				endcase
			end
			default: illegal_insn_o = 1'b1;
		endcase

		// rv32e has only x0..x15
		if (RV32E && ((rs1_used && instr_i[19]) || (rs2_used && instr_i[24]) ||
				(rd_used && instr_i[11]))) begin
			illegal_insn_o = 1'b1;
		end

		if (illegal_insn_o) begin
			rf_we_o         = 1'b0;
			lsu_req_o       = 1'b0;
			lsu_we_o        = 1'b0;
			branch_in_dec_o = 1'b0;
			jump_in_dec_o   = 1'b0;
		end
	end

	// the fsm picks its path by one class only
	always_comb begin
		a_one_class: assert final ($onehot0({branch_in_dec_o, jump_in_dec_o, lsu_req_o}))
			else $error("more than one instruction class decoded");
	end

endmodule

// File: id_stage.f
+incdir+tests
common/id_pkg.sv
decoder/id_decoder.sv
verilog/id_operands.sv
verilog/id_fsm.sv
verilog/id_stage.sv
tests/tb_id_stage.sv

// File: tests/id_ref_model.svh
`ifndef ID_REF_MODEL_SVH
`define ID_REF_MODEL_SVH

// immediates as sign-extended values of the chosen fields
function automatic data_t exp_imm12(input logic [11:0] imm);
	return {{20{imm[11]}}, imm};
endfunction

// branch and jump offsets are even, bit 0 is never encoded
function automatic data_t exp_imm13(input logic [12:0] imm);
	return {{19{imm[12]}}, imm[12:1], 1'b0};
endfunction

function automatic data_t exp_imm21(input logic [20:0] imm);
	return {{11{imm[20]}}, imm[20:1], 1'b0};
endfunction

function automatic data_t exp_imm_u(input logic [19:0] imm);
	return {imm, 12'h000};
endfunction

function automatic data_t exp_link_incr(input logic compressed);
	return compressed ? 32'd2 : 32'd4;
endfunction

function automatic lsu_type_e exp_lsu_type(input logic [2:0] f3);
	case (f3[1:0])
		2'b00:   return LSU_TYPE_B;
		2'b01:   return LSU_TYPE_H;
		default: return LSU_TYPE_W;
	endcase
endfunction

// lbu and lhu zero-extend, stores never sign-extend
function automatic logic exp_sign_ext(input logic is_load, input logic [2:0] f3);
	return is_load & ~f3[2];
endfunction

function automatic alu_op_e exp_branch_op(input logic [2:0] f3);
	case (f3)
		3'b000:  return ALU_EQ;
		3'b001:  return ALU_NE;
		3'b100:  return ALU_LT;
		3'b101:  return ALU_GE;
		3'b110:  return ALU_LTU;
		default: return ALU_GEU;
	endcase
endfunction

`endif

// File: tests/tb_id_stage.sv
`timescale 1ns/1ps

module tb_id_stage import id_pkg::*; ();

	localparam int CLK_PERIOD = 8;
	localparam int TEST_STEPS = 25;

	logic clk_i;
	logic rst_ni;
	logic instr_valid_i;
	instr_t instr_rdata_i;
	logic instr_is_compressed_i;
	data_t pc_id_i;
	data_t rf_rdata_a_i, rf_rdata_b_i;
	logic branch_decision_i, lsu_resp_valid_i, lsu_addr_incr_req_i;
	data_t lsu_addr_last_i, result_ex_i;
	reg_addr_t rf_raddr_a_o, rf_raddr_b_o, rf_waddr_o;
	logic rf_we_o;
	data_t rf_wdata_o;
	alu_op_e alu_operator_o;
	data_t alu_operand_a_o, alu_operand_b_o;
	logic lsu_req_o, lsu_we_o, lsu_sign_ext_o;
	lsu_type_e lsu_type_o;
	data_t lsu_wdata_o;
	logic pc_set_o, illegal_insn_o, instr_done_o;

	int errors;
	int tests_run;
	data_t drv_a, drv_b, drv_pc, drv_res;
	logic [11:0] imm12;
	logic [19:0] imm20;

	`include "id_ref_model.svh"

	id_stage #(
		.RV32E(1'b0)
	) dut_i (.*);

	initial clk_i = 1'b0;
	always #(CLK_PERIOD / 2) clk_i = ~clk_i;

	// instruction encoders
	function automatic instr_t enc_r(input logic [6:0] f7, input reg_addr_t rs2,
		input reg_addr_t rs1, input logic [2:0] f3, input reg_addr_t rd);
		return {f7, rs2, rs1, f3, rd, OPCODE_OP};
	endfunction

	function automatic instr_t enc_i(input logic [11:0] imm, input reg_addr_t rs1,
		input logic [2:0] f3, input reg_addr_t rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic instr_t enc_s(input logic [11:0] imm, input reg_addr_t rs2,
		input reg_addr_t rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], OPCODE_STORE};
	endfunction

	function automatic instr_t enc_b(input logic [12:0] imm, input reg_addr_t rs2,
		input reg_addr_t rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPCODE_BRANCH};
	endfunction

	function automatic instr_t enc_u(input logic [19:0] imm, input reg_addr_t rd,
		input logic [6:0] op);
		return {imm, rd, op};
	endfunction

	function automatic instr_t enc_j(input logic [20:0] imm, input reg_addr_t rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPCODE_JAL};
	endfunction

	task automatic report_mismatch(input string sig, input logic [31:0] got,
		input logic [31:0] exp);
		$display("error: %s = %h, expected %h", sig, got, exp);
		errors++;
	endtask

	task automatic end_test(input string name, input int err_start);
		tests_run++;
		if (errors == err_start) begin
			$display("test %-12s ok", name);
		end else begin
			$display("test %-12s %0d errors", name, errors - err_start);
		end
	endtask

	task automatic new_operands();
		drv_a   = $urandom;
		drv_b   = $urandom;
		drv_pc  = $urandom & 32'hffff_fffc;
		drv_res = $urandom;
	endtask

	task automatic present(input instr_t instr, input logic compressed);
		@(posedge clk_i);
		instr_valid_i         <= 1'b1;
		instr_rdata_i         <= instr;
		instr_is_compressed_i <= compressed;
		pc_id_i               <= drv_pc;
		rf_rdata_a_i          <= drv_a;
		rf_rdata_b_i          <= drv_b;
		result_ex_i           <= drv_res;
	endtask

	task automatic check_idle();
		if (instr_done_o !== 1'b0) report_mismatch("instr_done_o", instr_done_o, 0);
		if (pc_set_o !== 1'b0) report_mismatch("pc_set_o", pc_set_o, 0);
		if (rf_we_o !== 1'b0) report_mismatch("rf_we_o", rf_we_o, 0);
		if (lsu_req_o !== 1'b0) report_mismatch("lsu_req_o", lsu_req_o, 0);
		if (illegal_insn_o !== 1'b0) report_mismatch("illegal_insn_o", illegal_insn_o, 0);
	endtask

	// drop the instruction and expect a quiet cycle
	task automatic release_instr();
		@(posedge clk_i);
		instr_valid_i         <= 1'b0;
		instr_is_compressed_i <= 1'b0;
		branch_decision_i     <= 1'b0;
		lsu_resp_valid_i      <= 1'b0;
		lsu_addr_incr_req_i   <= 1'b0;
		@(negedge clk_i);
		check_idle();
	endtask

	task automatic run_alu(input string name, input instr_t instr, input alu_op_e exp_op,
		input data_t exp_a, input data_t exp_b, input reg_addr_t rs1, input reg_addr_t rs2,
		input reg_addr_t rd);
		int err_start;
		logic uses_rs1;
		logic uses_rs2;
		err_start = errors;
		// lui and auipc read no register, only op reads rs2
		uses_rs1  = (instr[6:0] != OPCODE_LUI) && (instr[6:0] != OPCODE_AUIPC);
		uses_rs2  = (instr[6:0] == OPCODE_OP);
		present(instr, 1'b0);
		@(negedge clk_i);
		if (alu_operator_o !== exp_op) report_mismatch("alu_operator_o", alu_operator_o, exp_op);
		if (alu_operand_a_o !== exp_a) report_mismatch("alu_operand_a_o", alu_operand_a_o, exp_a);
		if (alu_operand_b_o !== exp_b) report_mismatch("alu_operand_b_o", alu_operand_b_o, exp_b);
		if (uses_rs1 && rf_raddr_a_o !== rs1)
			report_mismatch("rf_raddr_a_o", rf_raddr_a_o, rs1);
		if (uses_rs2 && rf_raddr_b_o !== rs2)
			report_mismatch("rf_raddr_b_o", rf_raddr_b_o, rs2);
		if (rf_we_o !== 1'b1) report_mismatch("rf_we_o", rf_we_o, 1);
		if (rf_waddr_o !== rd) report_mismatch("rf_waddr_o", rf_waddr_o, rd);
		if (rf_wdata_o !== drv_res) report_mismatch("rf_wdata_o", rf_wdata_o, drv_res);
		if (instr_done_o !== 1'b1) report_mismatch("instr_done_o", instr_done_o, 1);
		release_instr();
		end_test(name, err_start);
	endtask

	task automatic run_lsu(input string name, input logic is_load, input logic [2:0] f3,
		input reg_addr_t rs1, input reg_addr_t rs2, input reg_addr_t rd, input logic incr);
		int err_start;
		int waits;
		int i;
		logic [11:0] imm;
		data_t last;
		err_start = errors;
		new_operands();
		imm   = $urandom;
		last  = $urandom;
		waits = $urandom_range(4, 1);
		if (is_load) begin
			present(enc_i(imm, rs1, f3, rd, OPCODE_LOAD), 1'b0);
		end else begin
			present(enc_s(imm, rs2, rs1, f3), 1'b0);
		end
		// a response in the request cycle belongs to an older access
		lsu_resp_valid_i <= 1'b1;
		@(negedge clk_i);
		if (lsu_req_o !== 1'b1) report_mismatch("lsu_req_o", lsu_req_o, 1);
		if (lsu_we_o !== !is_load) report_mismatch("lsu_we_o", lsu_we_o, !is_load);
		if (lsu_type_o !== exp_lsu_type(f3))
			report_mismatch("lsu_type_o", lsu_type_o, exp_lsu_type(f3));
		if (lsu_sign_ext_o !== exp_sign_ext(is_load, f3))
			report_mismatch("lsu_sign_ext_o", lsu_sign_ext_o, exp_sign_ext(is_load, f3));
		if (alu_operand_a_o !== drv_a) report_mismatch("alu_operand_a_o", alu_operand_a_o, drv_a);
		if (alu_operand_b_o !== exp_imm12(imm))
			report_mismatch("alu_operand_b_o", alu_operand_b_o, exp_imm12(imm));
		if (lsu_wdata_o !== drv_b) report_mismatch("lsu_wdata_o", lsu_wdata_o, drv_b);
		if (rf_raddr_a_o !== rs1) report_mismatch("rf_raddr_a_o", rf_raddr_a_o, rs1);
		if (!is_load && rf_raddr_b_o !== rs2) report_mismatch("rf_raddr_b_o", rf_raddr_b_o, rs2);
		if (instr_done_o !== 1'b0) report_mismatch("instr_done_o", instr_done_o, 0);
		if (rf_we_o !== 1'b0) report_mismatch("rf_we_o", rf_we_o, 0);
		@(posedge clk_i);
		lsu_resp_valid_i    <= 1'b0;
		lsu_addr_incr_req_i <= incr;
		lsu_addr_last_i     <= last;
		for (i = 0; i < waits; i++) begin
			@(negedge clk_i);
			if (lsu_req_o !== 1'b0) report_mismatch("lsu_req_o", lsu_req_o, 0);
			if (instr_done_o !== 1'b0) report_mismatch("instr_done_o", instr_done_o, 0);
			if (incr && alu_operand_a_o !== last)
				report_mismatch("alu_operand_a_o", alu_operand_a_o, last);
			if (incr && alu_operand_b_o !== 32'd4)
				report_mismatch("alu_operand_b_o", alu_operand_b_o, 32'd4);
			@(posedge clk_i);
		end
		lsu_resp_valid_i <= 1'b1;
		@(negedge clk_i);
		if (instr_done_o !== 1'b1) report_mismatch("instr_done_o", instr_done_o, 1);
		if (lsu_req_o !== 1'b0) report_mismatch("lsu_req_o", lsu_req_o, 0);
		if (rf_we_o !== is_load) report_mismatch("rf_we_o", rf_we_o, is_load);
		if (is_load && rf_waddr_o !== rd) report_mismatch("rf_waddr_o", rf_waddr_o, rd);
		release_instr();
		end_test(name, err_start);
	endtask

	task automatic run_branch(input string name, input logic [2:0] f3, input logic taken,
		input reg_addr_t rs1, input reg_addr_t rs2);
		int err_start;
		logic [12:0] imm;
		err_start = errors;
		new_operands();
		imm = $urandom;
		present(enc_b(imm, rs2, rs1, f3), 1'b0);
		branch_decision_i <= taken;
		@(negedge clk_i);
		if (alu_operator_o !== exp_branch_op(f3))
			report_mismatch("alu_operator_o", alu_operator_o, exp_branch_op(f3));
		if (alu_operand_a_o !== drv_a) report_mismatch("alu_operand_a_o", alu_operand_a_o, drv_a);
		if (alu_operand_b_o !== drv_b) report_mismatch("alu_operand_b_o", alu_operand_b_o, drv_b);
		if (rf_raddr_a_o !== rs1) report_mismatch("rf_raddr_a_o", rf_raddr_a_o, rs1);
		if (rf_raddr_b_o !== rs2) report_mismatch("rf_raddr_b_o", rf_raddr_b_o, rs2);
		if (pc_set_o !== 1'b0) report_mismatch("pc_set_o", pc_set_o, 0);
		if (instr_done_o !== !taken) report_mismatch("instr_done_o", instr_done_o, !taken);
		if (taken) begin
			// target cycle, decision is no longer needed
			@(posedge clk_i);
			branch_decision_i <= 1'b0;
			@(negedge clk_i);
			if (alu_operator_o !== ALU_ADD) report_mismatch("alu_operator_o", alu_operator_o, ALU_ADD);
			if (alu_operand_a_o !== drv_pc)
				report_mismatch("alu_operand_a_o", alu_operand_a_o, drv_pc);
			if (alu_operand_b_o !== exp_imm13(imm))
				report_mismatch("alu_operand_b_o", alu_operand_b_o, exp_imm13(imm));
			if (pc_set_o !== 1'b1) report_mismatch("pc_set_o", pc_set_o, 1);
			if (instr_done_o !== 1'b1) report_mismatch("instr_done_o", instr_done_o, 1);
		end
		release_instr();
		end_test(name, err_start);
	endtask

	task automatic run_jump(input string name, input logic is_jalr, input logic compressed,
		input reg_addr_t rs1, input reg_addr_t rd);
		int err_start;
		logic [20:0] imm;
		data_t exp_a;
		data_t exp_b;
		err_start = errors;
		new_operands();
		imm   = $urandom;
		exp_a = is_jalr ? drv_a : drv_pc;
		exp_b = is_jalr ? exp_imm12(imm[11:0]) : exp_imm21(imm);
		if (is_jalr) begin
			present(enc_i(imm[11:0], rs1, 3'b000, rd, OPCODE_JALR), compressed);
		end else begin
			present(enc_j(imm, rd), compressed);
		end
		@(negedge clk_i);
		if (alu_operator_o !== ALU_ADD) report_mismatch("alu_operator_o", alu_operator_o, ALU_ADD);
		if (alu_operand_a_o !== exp_a) report_mismatch("alu_operand_a_o", alu_operand_a_o, exp_a);
		if (alu_operand_b_o !== exp_b) report_mismatch("alu_operand_b_o", alu_operand_b_o, exp_b);
		if (pc_set_o !== 1'b1) report_mismatch("pc_set_o", pc_set_o, 1);
		if (rf_we_o !== 1'b0) report_mismatch("rf_we_o", rf_we_o, 0);
		if (instr_done_o !== 1'b0) report_mismatch("instr_done_o", instr_done_o, 0);
		// link cycle
		@(posedge clk_i);
		@(negedge clk_i);
		if (alu_operand_a_o !== drv_pc) report_mismatch("alu_operand_a_o", alu_operand_a_o, drv_pc);
		if (alu_operand_b_o !== exp_link_incr(compressed))
			report_mismatch("alu_operand_b_o", alu_operand_b_o, exp_link_incr(compressed));
		if (pc_set_o !== 1'b0) report_mismatch("pc_set_o", pc_set_o, 0);
		if (rf_we_o !== 1'b1) report_mismatch("rf_we_o", rf_we_o, 1);
		if (rf_waddr_o !== rd) report_mismatch("rf_waddr_o", rf_waddr_o, rd);
		if (rf_wdata_o !== drv_res) report_mismatch("rf_wdata_o", rf_wdata_o, drv_res);
		if (instr_done_o !== 1'b1) report_mismatch("instr_done_o", instr_done_o, 1);
		release_instr();
		end_test(name, err_start);
	endtask

	task automatic run_illegal(input string name, input instr_t instr);
		int err_start;
		err_start = errors;
		new_operands();
		present(instr, 1'b0);
		@(negedge clk_i);
		if (illegal_insn_o !== 1'b1) report_mismatch("illegal_insn_o", illegal_insn_o, 1);
		if (instr_done_o !== 1'b1) report_mismatch("instr_done_o", instr_done_o, 1);
		if (rf_we_o !== 1'b0) report_mismatch("rf_we_o", rf_we_o, 0);
		if (lsu_req_o !== 1'b0) report_mismatch("lsu_req_o", lsu_req_o, 0);
		if (pc_set_o !== 1'b0) report_mismatch("pc_set_o", pc_set_o, 0);
		release_instr();
		end_test(name, err_start);
	endtask

	task automatic run_reset_idle();
		int err_start;
		err_start = errors;
		@(negedge clk_i);
		check_idle();
		end_test("reset_idle", err_start);
	endtask

	// ends a run that hangs
	initial begin
		#(TEST_STEPS * 40 * CLK_PERIOD);
		$display("watchdog: tests did not finish within %0d ns", TEST_STEPS * 40 * CLK_PERIOD);
		$display("Simulation FAILED");
		$finish;
	end

	initial begin
		void'($urandom(52403));
		errors                = 0;
		tests_run             = 0;
		rst_ni                = 1'b0;
		instr_valid_i         = 1'b0;
		instr_rdata_i         = '0;
		instr_is_compressed_i = 1'b0;
		pc_id_i               = '0;
		rf_rdata_a_i          = '0;
		rf_rdata_b_i          = '0;
		branch_decision_i     = 1'b0;
		lsu_resp_valid_i      = 1'b0;
		lsu_addr_incr_req_i   = 1'b0;
		lsu_addr_last_i       = '0;
		result_ex_i           = '0;
		repeat (10) @(posedge clk_i);
		rst_ni <= 1'b1;
		run_reset_idle();

		new_operands();
		run_alu("add", enc_r(7'h00, 5'd5, 5'd12, 3'b000, 5'd1), ALU_ADD, drv_a, drv_b,
			5'd12, 5'd5, 5'd1);
		new_operands();
		run_alu("sub", enc_r(7'h20, 5'd31, 5'd2, 3'b000, 5'd17), ALU_SUB, drv_a, drv_b,
			5'd2, 5'd31, 5'd17);
		new_operands();
		run_alu("sltu", enc_r(7'h00, 5'd8, 5'd9, 3'b011, 5'd10), ALU_SLTU, drv_a, drv_b,
			5'd9, 5'd8, 5'd10);
		new_operands();
		run_alu("sra", enc_r(7'h20, 5'd4, 5'd6, 3'b101, 5'd7), ALU_SRA, drv_a, drv_b,
			5'd6, 5'd4, 5'd7);
		new_operands();
		imm12 = $urandom;
		run_alu("addi", enc_i(imm12, 5'd3, 3'b000, 5'd14, OPCODE_OP_IMM), ALU_ADD,
			drv_a, exp_imm12(imm12), 5'd3, 5'd0, 5'd14);
		new_operands();
		imm12 = $urandom;
		run_alu("xori", enc_i(imm12, 5'd25, 3'b100, 5'd26, OPCODE_OP_IMM), ALU_XOR,
			drv_a, exp_imm12(imm12), 5'd25, 5'd0, 5'd26);
		new_operands();
		imm20 = $urandom;
		run_alu("lui", enc_u(imm20, 5'd20, OPCODE_LUI), ALU_ADD, 32'h0, exp_imm_u(imm20),
			5'd0, 5'd0, 5'd20);
		new_operands();
		imm20 = $urandom;
		run_alu("auipc", enc_u(imm20, 5'd19, OPCODE_AUIPC), ALU_ADD,
			drv_pc, exp_imm_u(imm20), 5'd0, 5'd0, 5'd19);

		run_lsu("lw", 1'b1, 3'b010, 5'd11, 5'd0, 5'd12, 1'b0);
		run_lsu("lbu", 1'b1, 3'b100, 5'd13, 5'd0, 5'd28, 1'b0);
		run_lsu("lh", 1'b1, 3'b001, 5'd30, 5'd0, 5'd2, 1'b0);
		run_lsu("sw", 1'b0, 3'b010, 5'd22, 5'd21, 5'd0, 1'b0);
		run_lsu("sb", 1'b0, 3'b000, 5'd1, 5'd18, 5'd0, 1'b0);
		run_lsu("lw_misalign", 1'b1, 3'b010, 5'd8, 5'd0, 5'd9, 1'b1);

		run_branch("beq_not", 3'b000, 1'b0, 5'd1, 5'd2);
		run_branch("bne_taken", 3'b001, 1'b1, 5'd3, 5'd4);
		run_branch("bltu_taken", 3'b110, 1'b1, 5'd15, 5'd16);
		run_branch("bge_not", 3'b101, 1'b0, 5'd27, 5'd29);

		run_jump("jal", 1'b0, 1'b0, 5'd0, 5'd1);
		run_jump("jal_c", 1'b0, 1'b1, 5'd0, 5'd5);
		run_jump("jalr", 1'b1, 1'b0, 5'd6, 5'd1);

		run_illegal("bad_opcode", enc_i(12'h123, 5'd1, 3'b000, 5'd2, 7'h0b));
		run_illegal("bad_funct7", enc_r(7'h01, 5'd3, 5'd4, 3'b000, 5'd5));
		run_illegal("bad_store", enc_s(12'h010, 5'd6, 5'd7, 3'b011));

		$display("%0d tests run, %0d errors", tests_run, errors);
		if (errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

// File: verilog/id_fsm.sv
`timescale 1ns/1ps

module id_fsm import id_pkg::*; (
	input  logic clk_i,
	input  logic rst_ni,
	input  logic instr_valid_i,
	input  logic illegal_insn_i,
	input  logic rf_we_dec_i,
	input  logic lsu_req_dec_i,
	input  logic branch_in_dec_i,
	input  logic jump_in_dec_i,
	input  logic branch_decision_i,
	input  logic lsu_resp_valid_i,
	output logic instr_first_cycle_o,
	output logic rf_we_o,
	output logic lsu_req_o,
	output logic pc_set_o,
	output logic instr_done_o
);

	id_state_e state_q;
	id_state_e state_d;
	logic branch_set_q;
	logic branch_set_d;
	logic set_done_q;
	logic set_done_d;
	logic jump_set_raw;
	logic stall_mem;
	logic stall_branch;
	logic stall_jump;

	assign instr_first_cycle_o = instr_valid_i & (state_q == FIRST_CYCLE);

	always_comb begin
		state_d      = state_q;
		branch_set_d = 1'b0;
		jump_set_raw = 1'b0;
		stall_branch = 1'b0;
		stall_jump   = 1'b0;
		if (instr_valid_i) begin
			case (state_q)
				FIRST_CYCLE: begin
					if (lsu_req_dec_i) begin
						state_d = MULTI_CYCLE;
					end else if (branch_in_dec_i) begin
						// taken branch needs a second cycle for the target
						state_d      = branch_decision_i ? MULTI_CYCLE : FIRST_CYCLE;
						stall_branch = branch_decision_i;
						branch_set_d = branch_decision_i;
					end else if (jump_in_dec_i) begin
						state_d      = MULTI_CYCLE;
						stall_jump   = 1'b1;
						jump_set_raw = 1'b1;
					end
				end
				default: begin
					if (!lsu_req_dec_i || lsu_resp_valid_i) state_d = FIRST_CYCLE;
				end
			endcase
		end
	end

	// response in the request cycle belongs to an earlier access
	assign stall_mem = instr_valid_i & lsu_req_dec_i & (~lsu_resp_valid_i | instr_first_cycle_o);

	assign instr_done_o = instr_valid_i & ~(stall_mem | stall_branch | stall_jump);

	// pc set at most once per instruction
	assign set_done_d = (branch_set_q | jump_set_raw | set_done_q) & ~instr_done_o;
	assign pc_set_o   = (branch_set_q | jump_set_raw) & ~set_done_q;

	assign rf_we_o   = rf_we_dec_i & instr_done_o & ~illegal_insn_i;
	assign lsu_req_o = lsu_req_dec_i & instr_first_cycle_o & ~illegal_insn_i;

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			state_q      <= FIRST_CYCLE;
			branch_set_q <= 1'b0;
			set_done_q   <= 1'b0;
		end else begin
			state_q      <= state_d;
			branch_set_q <= branch_set_d;
			set_done_q   <= set_done_d;
		end
	end

	a_pc_set_once: assert property (@(posedge clk_i) disable iff (!rst_ni)
		pc_set_o && !instr_done_o |=> !pc_set_o)
		else $error("pc_set_o raised twice for one instruction");

	a_lsu_req_first: assert property (@(posedge clk_i) disable iff (!rst_ni)
		lsu_req_o |=> !lsu_req_o)
		else $error("lsu request outside the first cycle");

endmodule

// File: verilog/id_operands.sv
`timescale 1ns/1ps

module id_operands import id_pkg::*; (
	input  instr_t     instr_i,
	input  logic       instr_is_compressed_i,
	input  data_t      pc_i,
	input  data_t      rf_rdata_a_i,
	input  data_t      rf_rdata_b_i,
	input  data_t      lsu_addr_last_i,
	input  data_t      result_ex_i,
	input  logic       lsu_addr_incr_req_i,
	input  op_a_sel_e  op_a_sel_i,
	input  op_b_sel_e  op_b_sel_i,
	input  imm_b_sel_e imm_b_sel_i,
	output data_t      alu_operand_a_o,
	output data_t      alu_operand_b_o,
	output data_t      rf_wdata_o
);

	data_t imm_i_type;
	data_t imm_s_type;
	data_t imm_b_type;
	data_t imm_u_type;
	data_t imm_j_type;
	data_t imm_b;
	op_a_sel_e op_a_sel;
	op_b_sel_e op_b_sel;
	imm_b_sel_e imm_b_sel;

	assign imm_i_type = {{20{instr_i[31]}}, instr_i[31:20]};
	assign imm_s_type = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
	assign imm_b_type = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
		instr_i[11:8], 1'b0};
	assign imm_u_type = {instr_i[31:12], 12'b0};
	assign imm_j_type = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

	// lsu second access: last address + 4
	assign op_a_sel  = lsu_addr_incr_req_i ? OP_A_FWD : op_a_sel_i;
	assign op_b_sel  = lsu_addr_incr_req_i ? OP_B_IMM : op_b_sel_i;
	assign imm_b_sel = lsu_addr_incr_req_i ? IMM_B_INCR_ADDR : imm_b_sel_i;

	always_comb begin
		case (op_a_sel)
			OP_A_REG_A:  alu_operand_a_o = rf_rdata_a_i;
			OP_A_FWD:    alu_operand_a_o = lsu_addr_last_i;
			OP_A_CURRPC: alu_operand_a_o = pc_i;
			default:     alu_operand_a_o = '0;
		endcase
	end

	always_comb begin
		case (imm_b_sel)
			IMM_B_I:       imm_b = imm_i_type;
			IMM_B_S:       imm_b = imm_s_type;
			IMM_B_B:       imm_b = imm_b_type;
			IMM_B_U:       imm_b = imm_u_type;
			IMM_B_J:       imm_b = imm_j_type;
			// link offset depends on instruction size
			IMM_B_INCR_PC: imm_b = instr_is_compressed_i ? 32'd2 : 32'd4;
			default:       imm_b = 32'd4;
		endcase
	end

	assign alu_operand_b_o = (op_b_sel == OP_B_IMM) ? imm_b : rf_rdata_b_i;

	assign rf_wdata_o = result_ex_i;

endmodule

// File: verilog/id_stage.sv
`timescale 1ns/1ps

module id_stage import id_pkg::*; #(
	parameter bit RV32E = 1'b0
) (
	input  logic      clk_i,
	input  logic      rst_ni,
	input  logic      instr_valid_i,
	input  instr_t    instr_rdata_i,
	input  logic      instr_is_compressed_i,
	input  data_t     pc_id_i,
	input  data_t     rf_rdata_a_i,
	input  data_t     rf_rdata_b_i,
	input  logic      branch_decision_i,
	input  logic      lsu_resp_valid_i,
	input  logic      lsu_addr_incr_req_i,
	input  data_t     lsu_addr_last_i,
	input  data_t     result_ex_i,
	output reg_addr_t rf_raddr_a_o,
	output reg_addr_t rf_raddr_b_o,
	output reg_addr_t rf_waddr_o,
	output logic      rf_we_o,
	output data_t     rf_wdata_o,
	output alu_op_e   alu_operator_o,
	output data_t     alu_operand_a_o,
	output data_t     alu_operand_b_o,
	output logic      lsu_req_o,
	output logic      lsu_we_o,
	output lsu_type_e lsu_type_o,
	output logic      lsu_sign_ext_o,
	output data_t     lsu_wdata_o,
	output logic      pc_set_o,
	output logic      illegal_insn_o,
	output logic      instr_done_o
);

	logic instr_first_cycle;
	logic rf_we_dec;
	logic lsu_req_dec;
	logic branch_in_dec;
	logic jump_in_dec;
	logic illegal_insn_dec;
	op_a_sel_e op_a_sel;
	op_b_sel_e op_b_sel;
	imm_b_sel_e imm_b_sel;

	id_decoder #(
		.RV32E(RV32E)
	) decoder_i (
		.instr_i             (instr_rdata_i),
		.instr_first_cycle_i (instr_first_cycle),
		.rf_raddr_a_o        (rf_raddr_a_o),
		.rf_raddr_b_o        (rf_raddr_b_o),
		.rf_waddr_o          (rf_waddr_o),
		.rf_we_o             (rf_we_dec),
		.alu_operator_o      (alu_operator_o),
		.op_a_sel_o          (op_a_sel),
		.op_b_sel_o          (op_b_sel),
		.imm_b_sel_o         (imm_b_sel),
		.lsu_req_o           (lsu_req_dec),
		.lsu_we_o            (lsu_we_o),
		.lsu_type_o          (lsu_type_o),
		.lsu_sign_ext_o      (lsu_sign_ext_o),
		.branch_in_dec_o     (branch_in_dec),
		.jump_in_dec_o       (jump_in_dec),
		.illegal_insn_o      (illegal_insn_dec)
	);

	// only a valid instruction can be illegal
	assign illegal_insn_o = instr_valid_i & illegal_insn_dec;

	id_operands operands_i (
		.instr_i               (instr_rdata_i),
		.instr_is_compressed_i (instr_is_compressed_i),
		.pc_i                  (pc_id_i),
		.rf_rdata_a_i          (rf_rdata_a_i),
		.rf_rdata_b_i          (rf_rdata_b_i),
		.lsu_addr_last_i       (lsu_addr_last_i),
		.result_ex_i           (result_ex_i),
		.lsu_addr_incr_req_i   (lsu_addr_incr_req_i),
		.op_a_sel_i            (op_a_sel),
		.op_b_sel_i            (op_b_sel),
		.imm_b_sel_i           (imm_b_sel),
		.alu_operand_a_o       (alu_operand_a_o),
		.alu_operand_b_o       (alu_operand_b_o),
		.rf_wdata_o            (rf_wdata_o)
	);

	id_fsm fsm_i (
		.clk_i               (clk_i),
		.rst_ni              (rst_ni),
		.instr_valid_i       (instr_valid_i),
		.illegal_insn_i      (illegal_insn_o),
		.rf_we_dec_i         (rf_we_dec),
		.lsu_req_dec_i       (lsu_req_dec),
		.branch_in_dec_i     (branch_in_dec),
		.jump_in_dec_i       (jump_in_dec),
		.branch_decision_i   (branch_decision_i),
		.lsu_resp_valid_i    (lsu_resp_valid_i),
		.instr_first_cycle_o (instr_first_cycle),
		.rf_we_o             (rf_we_o),
		.lsu_req_o           (lsu_req_o),
		.pc_set_o            (pc_set_o),
		.instr_done_o        (instr_done_o)
	);

	// store data straight from the register file
	assign lsu_wdata_o = rf_rdata_b_i;

endmodule
